// File: tb/rect_patterns.txt
# test line: <points> <style>  style 0 plain, 1 cr, 2 spaces, 3 cr and spaces, 4 random
# then one "<x> <y>" line per point and the expected area (no lines follow style 4)
8 0
7 1
11 1
11 7
9 7
9 5
2 5
2 3
7 3
50
# single point
1 0
5 5
0
# empty rom
0 0
0
# wide coordinates with cr and spaces
3 3
262143 0
0 262143
131072 7
68719476736
# duplicate points
2 2
4 4
4 4
1
40 4

// File: build.f
+incdir+rtl
rtl/geom_pkg.sv
rtl/rom_pkg.sv
rtl/point_parser.sv
rtl/point_ram.sv
rtl/pair_scanner.sv
rtl/area_max.sv
rtl/rect_area_top.sv
tb/tb_rect_area.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the rect_area testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module tb_rect_area \
    -o tb_rect_area

./obj_dir/tb_rect_area | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: tb/tb_rect_area.sv
`timescale 1ns/1ps

module tb_rect_area;
    import geom_pkg::*;
    import rom_pkg::*;

    localparam int MAX_TESTS = 16;
    localparam int MAX_PTS   = 64;
    localparam int ROM_SIZE  = 4096;

    logic      clk;
    logic      rst;
    rom_byte_t rom_data;
    rom_addr_t rom_addr;
    area_t     result;
    logic      done;

    rom_byte_t rom [0:ROM_SIZE-1];
    int        rom_len;

    int     num_tests;
    int     test_count  [MAX_TESTS];
    int     test_style  [MAX_TESTS];
    area_t  test_expect [MAX_TESTS];
    coord_t test_x      [MAX_TESTS][MAX_PTS];
    coord_t test_y      [MAX_TESTS][MAX_PTS];

    int     errors;
    int     passed;
    int     failed;
    int     budget;
    logic   budget_ready;
    integer seed;

    rect_area_top u_dut (
        .clk(clk),
        .rst(rst),
        .rom_data_i(rom_data),
        .rom_addr_o(rom_addr),
        .result_o(result),
        .done_o(done)
    );

    always #2 clk = ~clk;

    // rom model answers on the falling edge
    always @(negedge clk) begin
        if (rom_addr < ROM_SIZE) begin
            rom_data <= rom[rom_addr[11:0]];
        end else begin
            rom_data <= 8'h00;
        end
    end

    task automatic read_data_line(input int fd, output string line, output bit ok);
        int r;
        ok = 1'b0;
        line = "";
        while (!ok && !$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 0 && line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic expect_fields(input int got, input int want);
        assert (got == want) else begin
            $display("pattern file has a line with %0d fields where %0d are needed",
                     got, want);
            errors++;
        end
    endtask

    // style bit0 adds cr, bit1 adds spaces, 4 means random points
    task automatic load_patterns();
        int    fd;
        int    n;
        int    cnt;
        int    style;
        int    a;
        int    b;
        area_t val;
        string line;
        bit    ok;
        num_tests = 0;
        fd = $fopen("tb/rect_patterns.txt", "r");
        if (fd != 0) begin
            read_data_line(fd, line, ok);
            while (ok && num_tests < MAX_TESTS) begin
                n = $sscanf(line, "%d %d", cnt, style);
                expect_fields(n, 2);
                if (cnt > MAX_PTS) begin
                    cnt = MAX_PTS;
                end
                test_count[num_tests]  = cnt;
                test_style[num_tests]  = style;
                test_expect[num_tests] = '0;
                for (int k = 0; k < cnt; k++) begin
                    if (style == 4) begin
                        test_x[num_tests][k] = coord_t'($unsigned($random(seed)) % 100000);
                        test_y[num_tests][k] = coord_t'($unsigned($random(seed)) % 100000);
                    end else begin
                        read_data_line(fd, line, ok);
                        n = $sscanf(line, "%d %d", a, b);
                        expect_fields(n, 2);
                        test_x[num_tests][k] = coord_t'(a);
                        test_y[num_tests][k] = coord_t'(b);
                    end
                end
                if (style != 4) begin
                    read_data_line(fd, line, ok);
                    n = $sscanf(line, "%d", val);
                    expect_fields(n, 1);
                    test_expect[num_tests] = val;
                end
                num_tests++;
                read_data_line(fd, line, ok);
            end
            $fclose(fd);
        end
    endtask

    task automatic put_text(input string s);
        for (int k = 0; k < s.len(); k++) begin
            rom[rom_len] = s[k];
            rom_len++;
        end
    endtask

    task automatic build_rom(input int t);
        string line;
        for (int k = 0; k < ROM_SIZE; k++) begin
            rom[k] = 8'h00;
        end
        rom_len = 0;
        for (int k = 0; k < test_count[t]; k++) begin
            if (test_style[t] == 2 || test_style[t] == 3) begin
                line = $sformatf(" %0d , %0d ", test_x[t][k], test_y[t][k]);
            end else begin
                line = $sformatf("%0d,%0d", test_x[t][k], test_y[t][k]);
            end
            put_text(line);
            if (test_style[t] == 1 || test_style[t] == 3) begin
                put_text("\r");
            end
            put_text("\n");
        end
    endtask

    // brute force over all unordered pairs with inclusive tile counts
    function automatic area_t max_area(input int t);
        longint best;
        longint dx;
        longint dy;
        best = 0;
        for (int i = 0; i < test_count[t]; i++) begin
            for (int j = i + 1; j < test_count[t]; j++) begin
                dx = longint'(test_x[t][i]) - longint'(test_x[t][j]);
                dy = longint'(test_y[t][i]) - longint'(test_y[t][j]);
                if (dx < 0) begin
                    dx = -dx;
                end
                if (dy < 0) begin
                    dy = -dy;
                end
                if ((dx + 1) * (dy + 1) > best) begin
                    best = (dx + 1) * (dy + 1);
                end
            end
        end
        return area_t'(best);
    endfunction

    task automatic check_value(input string name, input area_t got, input area_t exp,
                               inout int bad);
        assert (got === exp) else begin
            $display("[ERROR] %s = 0x%h, expected 0x%h", name, got, exp);
            bad++;
        end
    endtask

    task automatic run_test(input int t);
        area_t exp;
        area_t held;
        int    bad;
        bad = 0;
        exp = max_area(t);
        if (test_style[t] != 4) begin
            assert (exp == test_expect[t]) else begin
                $display("test %0d: pattern file expects 0x%h but the model gives 0x%h",
                         t, test_expect[t], exp);
                bad++;
            end
        end
        build_rom(t);
        @(negedge clk);
        rst = 1'b1;
        repeat (8) @(negedge clk);
        check_value("result_o", result, '0, bad);
        check_value("done_o", area_t'(done), '0, bad);
        rst = 1'b0;
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        check_value("result_o", result, exp, bad);
        // parser halts on the first nul above address zero
        check_value("rom_addr_o", area_t'(rom_addr), area_t'((rom_len > 0) ? rom_len : 1),
                    bad);
        held = result;
        // result must hold while done stays up
        repeat (20) begin
            @(negedge clk);
            check_value("done_o", area_t'(done), area_t'(1), bad);
            check_value("result_o", result, held, bad);
        end
        errors += bad;
        if (bad == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d: %0d points, area 0x%h, %s", t, test_count[t], result,
                 (bad == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        rom_data     = 8'h00;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        budget       = 0;
        budget_ready = 1'b0;
        seed         = 32'h180e;
        load_patterns();
        if (num_tests == 0) begin
            $display("no tests could be read from tb/rect_patterns.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            for (int t = 0; t < num_tests; t++) begin
                build_rom(t);
                budget += rom_len + 2 + test_count[t] * (test_count[t] - 1) / 2 + 100;
            end
            budget_ready = 1'b1;
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            $display("%0d tests, %0d passed, %0d failed, %0d errors",
                     num_tests, passed, failed, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (budget_ready === 1'b1);
        repeat (budget) @(posedge clk);
        $display("timeout: done_o did not rise within %0d cycles", budget);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: rtl/rect_area_top.sv
`timescale 1ns/1ps

module rect_area_top (
    input  logic               clk,
    input  logic               rst,
    input  rom_pkg::rom_byte_t rom_data_i,
    output rom_pkg::rom_addr_t rom_addr_o,
    output geom_pkg::area_t    result_o,
    output logic               done_o
);
    import geom_pkg::*;

    logic    wr_en;
    pt_idx_t wr_idx;
    point_t  wr_point;
    logic    parse_done;
    pt_idx_t point_count;
    pt_idx_t rd_idx_a;
    pt_idx_t rd_idx_b;
    point_t  rd_point_a;
    point_t  rd_point_b;
    logic    pair_valid;
    pair_t   pair;
    logic    scan_empty;

    point_parser u_parser (
        .clk(clk),
        .rst(rst),
        .rom_data_i(rom_data_i),
        .rom_addr_o(rom_addr_o),
        .wr_en_o(wr_en),
        .wr_idx_o(wr_idx),
        .wr_point_o(wr_point),
        .parse_done_o(parse_done),
        .point_count_o(point_count)
    );

    point_ram u_ram (
        .clk(clk),
        .wr_en_i(wr_en),
        .wr_idx_i(wr_idx),
        .wr_point_i(wr_point),
        .rd_idx_a_i(rd_idx_a),
        .rd_idx_b_i(rd_idx_b),
        .rd_point_a_o(rd_point_a),
        .rd_point_b_o(rd_point_b)
    );

    pair_scanner u_scanner (
        .clk(clk),
        .rst(rst),
        .parse_done_i(parse_done),
        .point_count_i(point_count),
        .rd_idx_a_o(rd_idx_a),
        .rd_idx_b_o(rd_idx_b),
        .rd_point_a_i(rd_point_a),
        .rd_point_b_i(rd_point_b),
        .pair_valid_o(pair_valid),
        .pair_o(pair),
        .scan_empty_o(scan_empty)
    );

    area_max u_area (
        .clk(clk),
        .rst(rst),
        .pair_valid_i(pair_valid),
        .pair_i(pair),
        .scan_empty_i(scan_empty),
        .result_o(result_o),
        .done_o(done_o)
    );

endmodule

// File: rtl/area_max.sv
`timescale 1ns/1ps

module area_max (
    input  logic            clk,
    input  logic            rst,
    input  logic            pair_valid_i,
    input  geom_pkg::pair_t pair_i,
    input  logic            scan_empty_i,
    output geom_pkg::area_t result_o,
    output logic            done_o
);
    import geom_pkg::*;

    coord_t dx;
    coord_t dy;
    area_t  width;
    area_t  height;
    area_t  area;

    area_t area_q;
    logic  valid_q;
    logic  last_q;
    logic  fin_q;
    area_t result_q;
    logic  done_q;

    assign dx = (pair_i.a.x > pair_i.b.x) ? (pair_i.a.x - pair_i.b.x)
                                          : (pair_i.b.x - pair_i.a.x);
    assign dy = (pair_i.a.y > pair_i.b.y) ? (pair_i.a.y - pair_i.b.y)
                                          : (pair_i.b.y - pair_i.a.y);

    // tiles are counted inclusively
    assign width  = area_t'(dx) + 1'b1;
    assign height = area_t'(dy) + 1'b1;
    assign area   = width * height;

    always_ff @(posedge clk) begin
        area_q <= area;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            fin_q    <= 1'b0;
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            valid_q <= pair_valid_i;
            last_q  <= pair_valid_i && pair_i.last;
            if (valid_q && (area_q > result_q)) begin
                result_q <= area_q;
            end
            // done follows the final update by a cycle
            fin_q <= last_q;
            if (fin_q || scan_empty_i) begin
                done_q <= 1'b1;
            end
        end
    end

    assign result_o = result_q;
    assign done_o   = done_q;

endmodule

// File: rtl/pair_scanner.sv
`timescale 1ns/1ps

module pair_scanner (
    input  logic              clk,
    input  logic              rst,
    input  logic              parse_done_i,
    input  geom_pkg::pt_idx_t point_count_i,
    output geom_pkg::pt_idx_t rd_idx_a_o,
    output geom_pkg::pt_idx_t rd_idx_b_o,
    input  geom_pkg::point_t  rd_point_a_i,
    input  geom_pkg::point_t  rd_point_b_i,
    output logic              pair_valid_o,
    output geom_pkg::pair_t   pair_o,
    output logic              scan_empty_o
);
    import geom_pkg::*;
    import rom_pkg::*;

    scan_state_e state;
    pt_idx_t     i_q;
    pt_idx_t     j_q;
    pt_idx_t     last_i_q;
    logic        valid_q;
    logic        last_q;
    logic        empty_q;

    logic    issue;
    logic    row_end;
    logic    issue_last;
    pt_idx_t next_j;

    // j runs 0..i-1 for each i
    assign issue      = (state == SCAN_RUNNING);
    assign next_j     = j_q + 1'b1;
    assign row_end    = (next_j == i_q);
    assign issue_last = row_end && (i_q == last_i_q);

    assign rd_idx_a_o = i_q;
    assign rd_idx_b_o = j_q;

    // ram data arrives one cycle after the address
    assign pair_valid_o = valid_q;
    assign pair_o       = '{a: rd_point_a_i, b: rd_point_b_i, last: last_q};
    assign scan_empty_o = empty_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SCAN_IDLE;
            i_q      <= '0;
            j_q      <= '0;
            last_i_q <= '0;
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            empty_q  <= 1'b0;
        end else begin
            valid_q <= issue;
            last_q  <= issue && issue_last;
            empty_q <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    if (parse_done_i) begin
                        if (point_count_i < pt_idx_t'(2)) begin
                            empty_q <= 1'b1;
                            state   <= SCAN_FINISHED;
                        end else begin
                            i_q      <= pt_idx_t'(1);
                            j_q      <= '0;
                            last_i_q <= point_count_i - 1'b1;
                            state    <= SCAN_RUNNING;
                        end
                    end
                end
                SCAN_RUNNING: begin
                    if (row_end) begin
                        j_q <= '0;
                        i_q <= i_q + 1'b1;
                        if (issue_last) begin
                            state <= SCAN_FINISHED;
                        end
                    end else begin
                        j_q <= next_j;
                    end
                end
                default: begin
                    state <= SCAN_FINISHED;
                end
            endcase
        end
    end

endmodule

// File: rtl/point_ram.sv
`timescale 1ns/1ps
`include "rect_area_settings.svh"

module point_ram (
    input  logic              clk,
    input  logic              wr_en_i,
    input  geom_pkg::pt_idx_t wr_idx_i,
    input  geom_pkg::point_t  wr_point_i,
    input  geom_pkg::pt_idx_t rd_idx_a_i,
    input  geom_pkg::pt_idx_t rd_idx_b_i,
    output geom_pkg::point_t  rd_point_a_o,
    output geom_pkg::point_t  rd_point_b_o
);
    import geom_pkg::*;

    localparam int ADDR_W = $clog2(`RA_MAX_POINTS);

    point_t mem [0:`RA_MAX_POINTS-1];

    // one write port, two registered read ports
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i[ADDR_W-1:0]] <= wr_point_i;
        end
        rd_point_a_o <= mem[rd_idx_a_i[ADDR_W-1:0]];
        rd_point_b_o <= mem[rd_idx_b_i[ADDR_W-1:0]];
    end

endmodule

// File: rtl/point_parser.sv
`timescale 1ns/1ps
`include "rect_area_settings.svh"

module point_parser (
    input  logic               clk,
    input  logic               rst,
    input  rom_pkg::rom_byte_t rom_data_i,
    output rom_pkg::rom_addr_t rom_addr_o,
    output logic               wr_en_o,
    output geom_pkg::pt_idx_t  wr_idx_o,
    output geom_pkg::point_t   wr_point_o,
    output logic               parse_done_o,
    output geom_pkg::pt_idx_t  point_count_o
);
    import geom_pkg::*;
    import rom_pkg::*;

    parse_state_e state;
    rom_addr_t    addr_q;
    coord_t       x_q;
    coord_t       y_q;
    logic         comma_seen;
    pt_idx_t      count_q;
    logic         done_q;

    logic   is_digit;
    logic   is_nul;
    logic   is_end;
    logic   has_room;
    logic   stop;
    coord_t digit;

    assign is_digit = (rom_data_i >= "0") && (rom_data_i <= "9");
    assign is_nul   = (rom_data_i == 8'h00);
    assign is_end   = (rom_data_i == 8'h0a) || is_nul;
    assign has_room = (count_q < `RA_MAX_POINTS);
    // a nul at address zero is just an empty first byte
    assign stop     = is_nul && (addr_q != '0);
    assign digit    = coord_t'(rom_data_i[3:0]);

    // point is complete in x_q/y_q when its terminator arrives
    assign wr_en_o    = (state == PARSE_READING) && is_end && comma_seen && has_room;
    assign wr_idx_o   = count_q;
    assign wr_point_o = '{x: x_q, y: y_q};

    assign rom_addr_o    = addr_q;
    assign parse_done_o  = done_q;
    assign point_count_o = count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= PARSE_READING;
            addr_q     <= '0;
            x_q        <= '0;
            y_q        <= '0;
            comma_seen <= 1'b0;
            count_q    <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state == PARSE_READING) begin
                if (!stop) begin
                    addr_q <= addr_q + 1'b1;
                end
                if (is_digit) begin
                    // value * 10 + digit
                    if (comma_seen) begin
                        y_q <= (y_q << 3) + (y_q << 1) + digit;
                    end else begin
                        x_q <= (x_q << 3) + (x_q << 1) + digit;
                    end
                end else if (rom_data_i == ",") begin
                    comma_seen <= 1'b1;
                end else if (is_end) begin
                    if (wr_en_o) begin
                        count_q <= count_q + 1'b1;
                    end
                    x_q        <= '0;
                    y_q        <= '0;
                    comma_seen <= 1'b0;
                    if (stop) begin
                        state  <= PARSE_FINISHED;
                        done_q <= 1'b1;
                    end
                end
                // cr, space and anything else only advance
            end
        end
    end

endmodule

// File: rtl/rom_pkg.sv
`include "rect_area_settings.svh"

package rom_pkg;

    // ascii text rom
    typedef logic [7:0] rom_byte_t;
    typedef logic [`RA_ROM_ADDR_W-1:0] rom_addr_t;

    typedef enum logic {
        PARSE_READING,
        PARSE_FINISHED
    } parse_state_e;

    // pair scan control
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUNNING,
        SCAN_FINISHED
    } scan_state_e;

endpackage

// File: rtl/geom_pkg.sv
`include "rect_area_settings.svh"

package geom_pkg;

    typedef logic [`RA_COORD_W-1:0] coord_t;
    typedef logic [`RA_IDX_W-1:0] pt_idx_t;
    typedef logic [`RA_AREA_W-1:0] area_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // two opposite corners plus the final pair flag of a scan
    typedef struct packed {
        point_t a;
        point_t b;
        logic   last;
    } pair_t;

endpackage

// File: rtl/rect_area_settings.svh
`ifndef RECT_AREA_SETTINGS_SVH
`define RECT_AREA_SETTINGS_SVH

// coordinate and index widths
`define RA_COORD_W 18
`define RA_IDX_W 10

// point memory depth
`define RA_MAX_POINTS 512

// text rom address width
`define RA_ROM_ADDR_W 17

`define RA_AREA_W 64

`endif
